//--- src/mem_axil_consts.svh
`ifndef MEM_AXIL_CONSTS_SVH
`define MEM_AXIL_CONSTS_SVH

// Physical address carried in the request header
`define MEM_ADDR_WIDTH 32

// Fill word and AXI data word share one width
`define MEM_DATA_WIDTH 64

// One strobe bit per data byte
`define MEM_STRB_WIDTH 8

// Low address bits that pick a byte lane
`define MEM_OFFSET_WIDTH 3

// Headers in flight between request and response
`define HDR_FIFO_DEPTH 2

`endif

//--- src/mem_axil_pkg.sv
`include "mem_axil_consts.svh"

package mem_axil_pkg;

  typedef logic [`MEM_ADDR_WIDTH-1:0] mem_addr_t;
  typedef logic [`MEM_DATA_WIDTH-1:0] mem_data_t;
  typedef logic [`MEM_STRB_WIDTH-1:0] mem_strb_t;

  // AXI bresp / rresp code
  typedef logic [1:0] axil_resp_t;

  // Both write types are treated as plain writes
  typedef enum logic [1:0]
  {
    e_mem_rd    = 2'b00
    , e_mem_wr    = 2'b01
    , e_mem_uc_rd = 2'b10
    , e_mem_uc_wr = 2'b11
  } mem_msg_type_e;

  // Access of 1, 2, 4 or 8 bytes
  typedef enum logic [1:0]
  {
    e_size_1   = 2'b00
    , e_size_2 = 2'b01
    , e_size_4 = 2'b10
    , e_size_8 = 2'b11
  } mem_msg_size_e;

endpackage

//--- src/mem_axil_req_if.sv
`timescale 1ns/1ps

// One accepted request on its way into the AXI master
interface mem_axil_req_if
  import mem_axil_pkg::*;
();

  logic          v;
  logic          is_write;
  mem_addr_t     addr;
  mem_msg_size_e size;
  mem_data_t     data;
  logic          ready;

  // Bridge side
  modport src
  (
    output v
    , output is_write
    , output addr
    , output size
    , output data
    , input  ready
  );

  // State machine side
  modport dst
  (
    input    v
    , input  is_write
    , input  addr
    , input  size
    , input  data
    , output ready
  );

endinterface

//--- src/mem_axil_header_fifo.sv
`timescale 1ns/1ps

`include "mem_axil_consts.svh"

module mem_axil_header_fifo
  import mem_axil_pkg::*;
(
  input  logic            clk_i
  , input  logic          rst_n_i

  , input  logic          push_i
  , input  mem_msg_type_e msg_type_i
  , input  mem_addr_t     addr_i
  , input  mem_msg_size_e size_i
  , output logic          ready_o

  , input  logic          pop_i
  , output logic          v_o
  , output mem_msg_type_e msg_type_o
  , output mem_addr_t     addr_o
  , output mem_msg_size_e size_o
);

  localparam int depth_lp     = `HDR_FIFO_DEPTH;
  localparam int ptr_width_lp = (depth_lp > 1) ? $clog2(depth_lp) : 1;
  localparam int cnt_width_lp = $clog2(depth_lp + 1);

  mem_msg_type_e           type_mem [depth_lp];
  mem_addr_t               addr_mem [depth_lp];
  mem_msg_size_e           size_mem [depth_lp];

  logic [ptr_width_lp-1:0] wr_ptr_q;
  logic [ptr_width_lp-1:0] rd_ptr_q;
  logic [cnt_width_lp-1:0] count_q;
  logic                    do_push;
  logic                    do_pop;

  // Wrap at the last entry
  function automatic logic [ptr_width_lp-1:0] ptr_next(input logic [ptr_width_lp-1:0] ptr);
    if (ptr == ptr_width_lp'(depth_lp - 1))
      return '0;
    return ptr + ptr_width_lp'(1);
  endfunction

  assign ready_o = (count_q != cnt_width_lp'(depth_lp));
  assign v_o     = (count_q != '0);
  assign do_push = push_i & ready_o;
  assign do_pop  = pop_i & v_o;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr_q <= ptr_next(wr_ptr_q);
      if (do_pop)
        rd_ptr_q <= ptr_next(rd_ptr_q);
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + cnt_width_lp'(1);
        2'b01:   count_q <= count_q - cnt_width_lp'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  // Header storage
  always_ff @(posedge clk_i)
  begin
    if (do_push)
    begin
      type_mem[wr_ptr_q] <= msg_type_i;
      addr_mem[wr_ptr_q] <= addr_i;
      size_mem[wr_ptr_q] <= size_i;
    end
  end

  // Head entry, stable until popped
  assign msg_type_o = type_mem[rd_ptr_q];
  assign addr_o     = addr_mem[rd_ptr_q];
  assign size_o     = size_mem[rd_ptr_q];

endmodule

//--- src/mem_axil_master_fsm.sv
`timescale 1ns/1ps

`include "mem_axil_consts.svh"

module mem_axil_master_fsm
  import mem_axil_pkg::*;
(
  input  logic         clk_i
  , input  logic       rst_n_i

  , mem_axil_req_if.dst req

  , output logic       resp_v_o
  , output mem_data_t  resp_data_o
  , input  logic       resp_yumi_i

  // Write address channel
  , output mem_addr_t  m_axil_awaddr_o
  , output logic [2:0] m_axil_awprot_o
  , output logic       m_axil_awvalid_o
  , input  logic       m_axil_awready_i

  // Write data channel
  , output mem_data_t  m_axil_wdata_o
  , output mem_strb_t  m_axil_wstrb_o
  , output logic       m_axil_wvalid_o
  , input  logic       m_axil_wready_i

  // Write response channel
  , input  axil_resp_t m_axil_bresp_i
  , input  logic       m_axil_bvalid_i
  , output logic       m_axil_bready_o

  // Read address channel
  , output mem_addr_t  m_axil_araddr_o
  , output logic [2:0] m_axil_arprot_o
  , output logic       m_axil_arvalid_o
  , input  logic       m_axil_arready_i

  // Read data channel
  , input  mem_data_t  m_axil_rdata_i
  , input  axil_resp_t m_axil_rresp_i
  , input  logic       m_axil_rvalid_i
  , output logic       m_axil_rready_o
);

  typedef enum logic [2:0]
  {
    e_idle
    , e_write
    , e_wresp
    , e_read
    , e_rresp
  } state_e;

  state_e                       state_q;
  state_e                       state_d;

  mem_addr_t                    addr_q;
  mem_data_t                    wdata_q;
  mem_strb_t                    strb_q;
  mem_strb_t                    strb_li;
  logic [`MEM_OFFSET_WIDTH-1:0] req_offset;

  logic                         aw_done_q;
  logic                         w_done_q;
  logic                         resp_v_q;
  mem_data_t                    resp_data_q;

  logic                         req_hs;
  logic                         aw_hs;
  logic                         w_hs;
  logic                         b_hs;
  logic                         ar_hs;
  logic                         r_hs;

  assign req.ready = (state_q == e_idle);
  assign req_hs    = req.v & req.ready;

  assign aw_hs = m_axil_awvalid_o & m_axil_awready_i;
  assign w_hs  = m_axil_wvalid_o & m_axil_wready_i;
  assign b_hs  = m_axil_bvalid_i & m_axil_bready_o;
  assign ar_hs = m_axil_arvalid_o & m_axil_arready_i;
  assign r_hs  = m_axil_rvalid_i & m_axil_rready_o;

  // Byte enables from access size and lane offset
  assign req_offset = req.addr[`MEM_OFFSET_WIDTH-1:0];

  always_comb
  begin
    case (req.size)
      e_size_1: strb_li = mem_strb_t'(1) << req_offset;
      e_size_2: strb_li = mem_strb_t'(3) << req_offset;
      e_size_4: strb_li = mem_strb_t'(15) << req_offset;
      default:  strb_li = '1;
    endcase
  end

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      e_idle:
        if (req_hs)
          state_d = req.is_write ? e_write : e_read;
      // AW and W may finish in either order
      e_write:
        if ((aw_done_q | aw_hs) & (w_done_q | w_hs))
          state_d = e_wresp;
      e_wresp:
        if (b_hs)
          state_d = e_idle;
      e_read:
        if (ar_hs)
          state_d = e_rresp;
      e_rresp:
        if (r_hs)
          state_d = e_idle;
      default:
        state_d = e_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_q   <= e_idle;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
      resp_v_q  <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      if ((state_q == e_write) && (state_d == e_write))
      begin
        aw_done_q <= aw_done_q | aw_hs;
        w_done_q  <= w_done_q | w_hs;
      end
      else
      begin
        aw_done_q <= 1'b0;
        w_done_q  <= 1'b0;
      end
      if (b_hs || r_hs)
        resp_v_q <= 1'b1;
      else if (resp_yumi_i)
        resp_v_q <= 1'b0;
    end
  end

  // Latched request and captured response data
  always_ff @(posedge clk_i)
  begin
    if (req_hs)
    begin
      addr_q  <= req.addr;
      wdata_q <= req.data;
      strb_q  <= strb_li;
    end
    if (b_hs)
      resp_data_q <= '0;
    else if (r_hs)
      resp_data_q <= m_axil_rdata_i;
  end

  assign m_axil_awaddr_o  = addr_q;
  assign m_axil_awprot_o  = 3'b000;
  assign m_axil_awvalid_o = (state_q == e_write) & ~aw_done_q;

  assign m_axil_wdata_o   = wdata_q;
  assign m_axil_wstrb_o   = strb_q;
  assign m_axil_wvalid_o  = (state_q == e_write) & ~w_done_q;

  // Hold off the response while the previous one is still waiting
  assign m_axil_bready_o  = (state_q == e_wresp) & ~resp_v_q;

  assign m_axil_araddr_o  = addr_q;
  assign m_axil_arprot_o  = 3'b000;
  assign m_axil_arvalid_o = (state_q == e_read);

  assign m_axil_rready_o  = (state_q == e_rresp) & ~resp_v_q;

  assign resp_v_o    = resp_v_q;
  assign resp_data_o = resp_data_q;

endmodule

//--- src/mem_axil_resp_pack.sv
`timescale 1ns/1ps

`include "mem_axil_consts.svh"

module mem_axil_resp_pack
  import mem_axil_pkg::*;
(
  input  mem_data_t                    data_i
  , input  logic [`MEM_OFFSET_WIDTH-1:0] sel_i
  , input  mem_msg_size_e              size_i
  , output mem_data_t                  data_o
);

  localparam int lanes_1_lp = `MEM_DATA_WIDTH / 8;
  localparam int lanes_2_lp = `MEM_DATA_WIDTH / 16;
  localparam int lanes_4_lp = `MEM_DATA_WIDTH / 32;

  logic [7:0]                   lane_1;
  logic [15:0]                  lane_2;
  logic [31:0]                  lane_4;
  logic [`MEM_OFFSET_WIDTH-1:0] base_2;
  logic [`MEM_OFFSET_WIDTH-1:0] base_4;

  // Lane base aligned down to the access size
  assign base_2 = {sel_i[`MEM_OFFSET_WIDTH-1:1], 1'b0};
  assign base_4 = {sel_i[`MEM_OFFSET_WIDTH-1:2], 2'b00};

  assign lane_1 = data_i[sel_i * 8 +: 8];
  assign lane_2 = data_i[base_2 * 8 +: 16];
  assign lane_4 = data_i[base_4 * 8 +: 32];

  // Replicate the selected lane over the whole word
  always_comb
  begin
    case (size_i)
      e_size_1: data_o = {lanes_1_lp{lane_1}};
      e_size_2: data_o = {lanes_2_lp{lane_2}};
      e_size_4: data_o = {lanes_4_lp{lane_4}};
      default:  data_o = data_i;
    endcase
  end

endmodule

//--- src/mem_axil_bridge.sv
`timescale 1ns/1ps

`include "mem_axil_consts.svh"

module mem_axil_bridge
  import mem_axil_pkg::*;
(
  input  logic           clk_i
  , input  logic         rst_n_i

  // Upstream requests
  , input  mem_msg_type_e mem_fwd_msg_type_i
  , input  mem_addr_t    mem_fwd_addr_i
  , input  mem_msg_size_e mem_fwd_size_i
  , input  mem_data_t    mem_fwd_data_i
  , input  logic         mem_fwd_v_i
  , output logic         mem_fwd_ready_and_o

  // Upstream responses
  , output mem_msg_type_e mem_rev_msg_type_o
  , output mem_addr_t    mem_rev_addr_o
  , output mem_msg_size_e mem_rev_size_o
  , output mem_data_t    mem_rev_data_o
  , output logic         mem_rev_v_o
  , input  logic         mem_rev_ready_and_i

  // AXI4-Lite master
  , output mem_addr_t    m_axil_awaddr_o
  , output logic [2:0]   m_axil_awprot_o
  , output logic         m_axil_awvalid_o
  , input  logic         m_axil_awready_i
  , output mem_data_t    m_axil_wdata_o
  , output mem_strb_t    m_axil_wstrb_o
  , output logic         m_axil_wvalid_o
  , input  logic         m_axil_wready_i
  , input  axil_resp_t   m_axil_bresp_i
  , input  logic         m_axil_bvalid_i
  , output logic         m_axil_bready_o
  , output mem_addr_t    m_axil_araddr_o
  , output logic [2:0]   m_axil_arprot_o
  , output logic         m_axil_arvalid_o
  , input  logic         m_axil_arready_i
  , input  mem_data_t    m_axil_rdata_i
  , input  axil_resp_t   m_axil_rresp_i
  , input  logic         m_axil_rvalid_i
  , output logic         m_axil_rready_o
);

  mem_axil_req_if req_if ();

  logic      hdr_ready;
  logic      hdr_v;
  logic      fwd_hs;
  logic      rev_hs;
  logic      resp_v;
  mem_data_t resp_data;

  // Accept only with room for the header and an idle master
  assign mem_fwd_ready_and_o = req_if.ready & hdr_ready;
  assign fwd_hs              = mem_fwd_v_i & mem_fwd_ready_and_o;

  assign req_if.v        = mem_fwd_v_i & hdr_ready;
  assign req_if.is_write = mem_fwd_msg_type_i inside {e_mem_wr, e_mem_uc_wr};
  assign req_if.addr     = mem_fwd_addr_i;
  assign req_if.size     = mem_fwd_size_i;
  assign req_if.data     = mem_fwd_data_i;

  assign mem_rev_v_o = hdr_v & resp_v;
  assign rev_hs      = mem_rev_v_o & mem_rev_ready_and_i;

  mem_axil_header_fifo i_header_fifo
  (
    .clk_i        (clk_i)
    , .rst_n_i    (rst_n_i)
    , .push_i     (fwd_hs)
    , .msg_type_i (mem_fwd_msg_type_i)
    , .addr_i     (mem_fwd_addr_i)
    , .size_i     (mem_fwd_size_i)
    , .ready_o    (hdr_ready)
    , .pop_i      (rev_hs)
    , .v_o        (hdr_v)
    , .msg_type_o (mem_rev_msg_type_o)
    , .addr_o     (mem_rev_addr_o)
    , .size_o     (mem_rev_size_o)
  );

  mem_axil_master_fsm i_master_fsm
  (
    .clk_i         (clk_i)
    , .rst_n_i     (rst_n_i)
    , .req         (req_if)
    , .resp_v_o    (resp_v)
    , .resp_data_o (resp_data)
    , .resp_yumi_i (rev_hs)
    , .*
  );

  // Read data packed against the head header
  mem_axil_resp_pack i_resp_pack
  (
    .data_i   (resp_data)
    , .sel_i  (mem_rev_addr_o[`MEM_OFFSET_WIDTH-1:0])
    , .size_i (mem_rev_size_o)
    , .data_o (mem_rev_data_o)
  );

endmodule

//--- testbench/axil_slave_model.sv
`timescale 1ns/1ps

module axil_slave_model
  import mem_axil_pkg::*;
(
  input  logic         clk_i
  , input  logic       rst_n_i
  , input  mem_addr_t  awaddr_i
  , input  logic       awvalid_i
  , output logic       awready_o
  , input  mem_data_t  wdata_i
  , input  mem_strb_t  wstrb_i
  , input  logic       wvalid_i
  , output logic       wready_o
  , output axil_resp_t bresp_o
  , output logic       bvalid_o
  , input  logic       bready_i
  , input  mem_addr_t  araddr_i
  , input  logic       arvalid_i
  , output logic       arready_o
  , output mem_data_t  rdata_o
  , output axil_resp_t rresp_o
  , output logic       rvalid_o
  , input  logic       rready_i
);

  // Sixteen 64-bit words, indexed by address bits 6:3
  mem_data_t mem [16];
  mem_addr_t aw_addr_q;
  mem_data_t w_data_q;
  mem_strb_t w_strb_q;
  logic      aw_got_q;
  logic      w_got_q;
  logic      b_pend_q;
  logic      r_pend_q;

  assign bresp_o = '0;
  assign rresp_o = '0;

  initial
  begin
    for (int i = 0; i < 16; i++)
      mem[i] = '0;
  end

  always @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      awready_o <= 1'b0;
      wready_o  <= 1'b0;
      arready_o <= 1'b0;
      bvalid_o  <= 1'b0;
      rvalid_o  <= 1'b0;
      rdata_o   <= '0;
      aw_got_q  <= 1'b0;
      w_got_q   <= 1'b0;
      b_pend_q  <= 1'b0;
      r_pend_q  <= 1'b0;
    end
    else
    begin
      // Random ready patterns give random channel delays
      awready_o <= 1'($urandom_range(0, 1));
      wready_o  <= 1'($urandom_range(0, 1));
      arready_o <= 1'($urandom_range(0, 1));
      if (awvalid_i && awready_o)
      begin
        aw_addr_q <= awaddr_i;
        aw_got_q  <= 1'b1;
      end
      if (wvalid_i && wready_o)
      begin
        w_data_q <= wdata_i;
        w_strb_q <= wstrb_i;
        w_got_q  <= 1'b1;
      end
      if (aw_got_q && w_got_q)
      begin
        for (int b = 0; b < 8; b++)
          if (w_strb_q[b])
            mem[aw_addr_q[6:3]][b*8 +: 8] <= w_data_q[b*8 +: 8];
        aw_got_q <= 1'b0;
        w_got_q  <= 1'b0;
        b_pend_q <= 1'b1;
      end
      if (b_pend_q && !bvalid_o && ($urandom_range(0, 1) != 0))
      begin
        bvalid_o <= 1'b1;
        b_pend_q <= 1'b0;
      end
      if (bvalid_o && bready_i)
        bvalid_o <= 1'b0;
      if (arvalid_i && arready_o)
      begin
        rdata_o  <= mem[araddr_i[6:3]];
        r_pend_q <= 1'b1;
      end
      if (r_pend_q && !rvalid_o && ($urandom_range(0, 1) != 0))
      begin
        rvalid_o <= 1'b1;
        r_pend_q <= 1'b0;
      end
      if (rvalid_o && rready_i)
        rvalid_o <= 1'b0;
    end
  end

endmodule

//--- testbench/mem_axil_bridge_asserts.sv
`timescale 1ns/1ps

module mem_axil_bridge_asserts
  import mem_axil_pkg::*;
(
  input  logic          clk_i
  , input  logic        rst_n_i
  , input  mem_msg_type_e mem_rev_msg_type_o
  , input  mem_addr_t   mem_rev_addr_o
  , input  mem_msg_size_e mem_rev_size_o
  , input  mem_data_t   mem_rev_data_o
  , input  logic        mem_rev_v_o
  , input  logic        mem_rev_ready_and_i
  , input  mem_addr_t   m_axil_awaddr_o
  , input  logic        m_axil_awvalid_o
  , input  logic        m_axil_awready_i
  , input  mem_data_t   m_axil_wdata_o
  , input  mem_strb_t   m_axil_wstrb_o
  , input  logic        m_axil_wvalid_o
  , input  logic        m_axil_wready_i
  , input  mem_addr_t   m_axil_araddr_o
  , input  logic        m_axil_arvalid_o
  , input  logic        m_axil_arready_i
);

  int fail_count = 0;

  // Valids hold with a stable payload until the handshake
  a_aw_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    m_axil_awvalid_o && !m_axil_awready_i |=> m_axil_awvalid_o && $stable(m_axil_awaddr_o))
    else begin fail_count++; $error("awvalid dropped or awaddr changed before awready"); end

  a_w_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    m_axil_wvalid_o && !m_axil_wready_i
      |=> m_axil_wvalid_o && $stable(m_axil_wdata_o) && $stable(m_axil_wstrb_o))
    else begin fail_count++; $error("wvalid dropped or write payload changed before wready"); end

  a_ar_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    m_axil_arvalid_o && !m_axil_arready_i |=> m_axil_arvalid_o && $stable(m_axil_araddr_o))
    else begin fail_count++; $error("arvalid dropped or araddr changed before arready"); end

  // Response frozen under back-pressure
  a_rev_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_rev_v_o && !mem_rev_ready_and_i
      |=> mem_rev_v_o && $stable(mem_rev_msg_type_o) && $stable(mem_rev_addr_o)
        && $stable(mem_rev_size_o) && $stable(mem_rev_data_o))
    else begin fail_count++; $error("response changed while stalled"); end

endmodule

//--- testbench/tb_mem_axil_bridge.sv
`timescale 1ns/1ps

module tb_mem_axil_bridge;
  import mem_axil_pkg::*;

  localparam int num_rand_lp = 60;
  localparam int num_req_lp  = 16 + num_rand_lp + 3;
  localparam time timeout_lp = 400 * num_req_lp * 20;

  typedef struct packed
  {
    mem_msg_type_e t;
    mem_addr_t     a;
    mem_msg_size_e s;
    mem_data_t     d;
  } resp_t;

  logic          clk_i;
  logic          rst_n_i;
  mem_msg_type_e mem_fwd_msg_type_i;
  mem_msg_type_e mem_rev_msg_type_o;
  mem_addr_t     mem_fwd_addr_i;
  mem_addr_t     mem_rev_addr_o;
  mem_msg_size_e mem_fwd_size_i;
  mem_msg_size_e mem_rev_size_o;
  mem_data_t     mem_fwd_data_i;
  mem_data_t     mem_rev_data_o;
  logic          mem_fwd_v_i;
  logic          mem_fwd_ready_and_o;
  logic          mem_rev_v_o;
  logic          mem_rev_ready_and_i;
  mem_addr_t     m_axil_awaddr_o;
  mem_addr_t     m_axil_araddr_o;
  logic [2:0]    m_axil_awprot_o;
  logic [2:0]    m_axil_arprot_o;
  logic          m_axil_awvalid_o;
  logic          m_axil_awready_i;
  logic          m_axil_wvalid_o;
  logic          m_axil_wready_i;
  mem_data_t     m_axil_wdata_o;
  mem_data_t     m_axil_rdata_i;
  mem_strb_t     m_axil_wstrb_o;
  axil_resp_t    m_axil_bresp_i;
  axil_resp_t    m_axil_rresp_i;
  logic          m_axil_bvalid_i;
  logic          m_axil_bready_o;
  logic          m_axil_arvalid_o;
  logic          m_axil_arready_i;
  logic          m_axil_rvalid_i;
  logic          m_axil_rready_o;

  logic [7:0] mirror [128];
  resp_t      exp_q [$];
  mem_addr_t  cur_addr;
  mem_data_t  cur_data;
  mem_strb_t  cur_strb;
  logic       hold_rev;
  int         addr_hs_count;

  mem_axil_bridge i_mem_axil_bridge (.*);

  bind mem_axil_bridge mem_axil_bridge_asserts i_bridge_asserts (.*);

  axil_slave_model i_slave
  (
    .clk_i      (clk_i)
    , .rst_n_i  (rst_n_i)
    , .awaddr_i (m_axil_awaddr_o)
    , .awvalid_i (m_axil_awvalid_o)
    , .awready_o (m_axil_awready_i)
    , .wdata_i  (m_axil_wdata_o)
    , .wstrb_i  (m_axil_wstrb_o)
    , .wvalid_i (m_axil_wvalid_o)
    , .wready_o (m_axil_wready_i)
    , .bresp_o  (m_axil_bresp_i)
    , .bvalid_o (m_axil_bvalid_i)
    , .bready_i (m_axil_bready_o)
    , .araddr_i (m_axil_araddr_o)
    , .arvalid_i (m_axil_arvalid_o)
    , .arready_o (m_axil_arready_i)
    , .rdata_o  (m_axil_rdata_i)
    , .rresp_o  (m_axil_rresp_i)
    , .rvalid_o (m_axil_rvalid_i)
    , .rready_i (m_axil_rready_o)
  );

  task automatic fail_now(input string msg);
    $display("FAIL at %0t: %s", $time, msg);
    $display("=== FAIL ===");
    $fatal(1, "Check failed");
  endtask

  // Addressed lane aligned to the size, repeated over eight bytes
  function automatic mem_data_t expect_read(input mem_addr_t a, input mem_msg_size_e s);
    int bytes;
    int base;
    mem_data_t r;
    bytes = 1 << s;
    base  = int'(a[6:0]) & ~(bytes - 1);
    for (int i = 0; i < 8; i++)
      r[i*8 +: 8] = mirror[base + (i % bytes)];
    return r;
  endfunction

  task automatic send_req(input mem_msg_type_e t, input mem_addr_t a,
                          input mem_msg_size_e s, input mem_data_t d);
    resp_t e;
    int bytes;
    bit wr;
    @(negedge clk_i);
    mem_fwd_msg_type_i = t;
    mem_fwd_addr_i     = a;
    mem_fwd_size_i     = s;
    mem_fwd_data_i     = d;
    mem_fwd_v_i        = 1'b1;
    @(posedge clk_i);
    while (!mem_fwd_ready_and_o)
      @(posedge clk_i);
    bytes    = 1 << s;
    wr       = (t == e_mem_wr) || (t == e_mem_uc_wr);
    cur_addr = a;
    cur_data = d;
    cur_strb = (s == e_size_8) ? 8'hff : 8'(((1 << bytes) - 1) << a[2:0]);
    e.t = t;
    e.a = a;
    e.s = s;
    e.d = '0;
    if (wr)
    begin
      for (int b = 0; b < 8; b++)
        if (cur_strb[b])
          mirror[{a[6:3], 3'(b)}] = d[b*8 +: 8];
    end
    else
      e.d = expect_read(a, s);
    exp_q.push_back(e);
    @(negedge clk_i);
    mem_fwd_v_i = 1'b0;
  endtask

  initial
  begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  initial
  begin
    #(timeout_lp);
    $display("Timeout: not every response arrived in time");
    $display("=== FAIL ===");
    $fatal(1, "Watchdog expired");
  end

  // Random stall pattern on the response port
  initial
  begin
    forever
    begin
      @(negedge clk_i);
      if (rst_n_i)
        mem_rev_ready_and_i = hold_rev ? 1'b0 : ($urandom_range(0, 3) != 0);
    end
  end

  always @(posedge clk_i)
  begin
    resp_t e;
    if (rst_n_i)
    begin
      if (i_mem_axil_bridge.i_bridge_asserts.fail_count != 0)
        fail_now("a bound AXI or response assertion failed");
      if (m_axil_awvalid_o && m_axil_awready_i)
      begin
        addr_hs_count++;
        assert (m_axil_awaddr_o == cur_addr && m_axil_awprot_o == 3'b000)
          else fail_now($sformatf("awaddr %h awprot %0d expected %h and 0",
            m_axil_awaddr_o, m_axil_awprot_o, cur_addr));
      end
      if (m_axil_arvalid_o && m_axil_arready_i)
      begin
        addr_hs_count++;
        assert (m_axil_araddr_o == cur_addr && m_axil_arprot_o == 3'b000)
          else fail_now($sformatf("araddr %h arprot %0d expected %h and 0",
            m_axil_araddr_o, m_axil_arprot_o, cur_addr));
      end
      if (m_axil_wvalid_o && m_axil_wready_i)
        assert (m_axil_wstrb_o == cur_strb && m_axil_wdata_o == cur_data)
          else fail_now($sformatf("wstrb %h wdata %h expected %h and %h",
            m_axil_wstrb_o, m_axil_wdata_o, cur_strb, cur_data));
      if (mem_rev_v_o && mem_rev_ready_and_i)
      begin
        assert (exp_q.size() != 0) else fail_now("response with no request outstanding");
        e = exp_q.pop_front();
        assert (mem_rev_msg_type_o == e.t && mem_rev_addr_o == e.a && mem_rev_size_o == e.s)
          else fail_now($sformatf("header %0d/%h/%0d expected %0d/%h/%0d",
            mem_rev_msg_type_o, mem_rev_addr_o, mem_rev_size_o, e.t, e.a, e.s));
        assert (mem_rev_data_o == e.d)
          else fail_now($sformatf("data %h expected %h at %h", mem_rev_data_o, e.d, e.a));
      end
    end
  end

  initial
  begin
    mem_msg_size_e s;
    mem_addr_t a;
    int bytes;
    int ah0;
    void'($urandom(70));
    rst_n_i = 1'b0;
    mem_fwd_msg_type_i = e_mem_rd;
    mem_fwd_addr_i = '0;
    mem_fwd_size_i = e_size_1;
    mem_fwd_data_i = '0;
    mem_fwd_v_i = 1'b0;
    mem_rev_ready_and_i = 1'b0;
    hold_rev = 1'b0;
    addr_hs_count = 0;
    for (int i = 0; i < 128; i++)
      mirror[i] = '0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    assert (!mem_rev_v_o && !m_axil_awvalid_o && !m_axil_wvalid_o && !m_axil_arvalid_o
            && !m_axil_bready_o && !m_axil_rready_o && mem_fwd_ready_and_o)
      else fail_now("outputs not in their reset state");
    // Fill every word first
    for (int w = 0; w < 16; w++)
      send_req(e_mem_wr, mem_addr_t'(w * 8), e_size_8, {$urandom, $urandom});
    for (int i = 0; i < num_rand_lp; i++)
    begin
      s     = mem_msg_size_e'($urandom_range(0, 3));
      bytes = 1 << s;
      a     = mem_addr_t'(($urandom_range(0, 15) * 8) + ($urandom_range(0, 7) & ~(bytes - 1)));
      send_req(mem_msg_type_e'($urandom_range(0, 3)), a, s, {$urandom, $urandom});
    end
    while (exp_q.size() != 0)
      @(posedge clk_i);
    // Two in flight with the response port stalled, the third refused
    hold_rev = 1'b1;
    ah0 = addr_hs_count;
    send_req(e_mem_wr, 32'h10, e_size_4, {$urandom, $urandom});
    send_req(e_mem_rd, 32'h12, e_size_2, '0);
    @(negedge clk_i);
    mem_fwd_msg_type_i = e_mem_uc_rd;
    mem_fwd_addr_i = 32'h11;
    mem_fwd_size_i = e_size_1;
    mem_fwd_v_i = 1'b1;
    repeat (30)
    begin
      @(posedge clk_i);
      assert (!mem_fwd_ready_and_o) else fail_now("third request accepted with full queue");
    end
    assert (addr_hs_count == ah0 + 2) else fail_now("second request not issued on AXI");
    hold_rev = 1'b0;
    send_req(e_mem_uc_rd, 32'h11, e_size_1, '0);
    while (exp_q.size() != 0)
      @(posedge clk_i);
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    if (i_mem_axil_bridge.i_bridge_asserts.fail_count == 0)
    begin
      $display("=== PASS ===");
      $finish;
    end
    else
    begin
      $display("=== FAIL ===");
      $fatal(1, "Bound assertions failed");
    end
  end

endmodule

//--- compile.f
+incdir+src
src/mem_axil_pkg.sv
src/mem_axil_req_if.sv
src/mem_axil_header_fifo.sv
src/mem_axil_master_fsm.sv
src/mem_axil_resp_pack.sv
src/mem_axil_bridge.sv
testbench/axil_slave_model.sv
testbench/mem_axil_bridge_asserts.sv
testbench/tb_mem_axil_bridge.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mem_axil_bridge
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP BUILD_DIR LOG FILELIST VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "=== PASS ===" $(LOG); then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
